// File: tb/cache_testdata.txt
// each line holds op, address, byte strobe, write data and expected read data in hex
// op bit 0 marks a write and bit 1 a request that has to hit
// the ff line ends the list
0 00001024 0 00000000 ffffefdb
2 00001024 0 00000000 ffffefdb
0 00002028 0 00000000 ffffdfd7
0 0000302c 0 00000000 ffffcfd3
0 00001024 0 00000000 ffffefdb
0 00005040 0 00000000 ffffafbf
3 00005040 3 12345678 00000000
2 00005040 0 00000000 ffff5678
1 00006058 c aabbccdd 00000000
2 00006058 0 00000000 aabb9fa7
1 00007074 f 11111111 00000000
1 00008074 1 222222ee 00000000
1 00009074 6 33cafe33 00000000
0 00007074 0 00000000 11111111
0 00008074 0 00000000 ffff7fee
0 00009074 0 00000000 ffcafe8b
ff 00000000 0 00000000 00000000

// File: verilog.f
logic/cache_geom_pkg.sv
logic/cache_ctrl_pkg.sv
logic/cache_way.sv
logic/miss_unit.sv
logic/cache_ctrl.sv
logic/cache_top.sv
tb/mem_model.sv
tb/cache_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
    verilator --binary --assert --top-module cache_tb -f verilog.f &&
    ./obj_dir/Vcache_tb | tee /dev/stderr | grep -q "Regression passed" ||
    exit 1

// File: tb/cache_tb.sv
`default_nettype none

module cache_tb;

    localparam int MAX_REQ = 32;

    logic                      clk;
    logic                      resetn;
    logic                      valid;
    cache_ctrl_pkg::cache_op_t op;
    logic [19:0]               tag;
    logic [7:0]                index;
    logic [3:0]                offset;
    logic [3:0]                wstrb;
    logic [31:0]               wdata;
    logic                      addr_ok, data_ok;
    logic [31:0]               rdata;
    logic                      rd_req, rd_rdy;
    logic [31:0]               rd_addr;
    logic                      ret_valid, ret_last;
    logic [31:0]               ret_data;
    logic                      wr_req, wr_rdy;
    logic [31:0]               wr_addr;
    logic [127:0]              wr_data;
    bit                        stored_lines [logic [27:0]];
    logic [31:0]               stim [MAX_REQ*5];
    int                        k;

    cache_top dut (.*);

    mem_model mem (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else fail_run($sformatf("MISMATCH at %0t: %s is %h, expected %h",
                                $time, name, got, exp));
    endtask

    // code bit 0 marks a write, bit 1 a request that has to hit
    task automatic run_request(input int n);
        logic [7:0] code;
        int         waited;
        code = stim[n*5][7:0];
        @(posedge clk);
        #10;
        valid = 1'b1;
        op    = code[0] ? cache_ctrl_pkg::op_write : cache_ctrl_pkg::op_read;
        {tag, index, offset} = stim[n*5+1];
        wstrb = stim[n*5+2][3:0];
        wdata = stim[n*5+3];
        if (code[0])
            stored_lines[{tag, index}] = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!addr_ok) begin
            waited++;
            assert (waited < 100) else fail_run("timed out waiting for addr_ok");
            @(negedge clk);
        end
        @(posedge clk);
        #10;
        valid  = 1'b0;
        waited = 1;
        @(negedge clk);
        while (!data_ok) begin
            waited++;
            assert (waited < 100) else fail_run("timed out waiting for data_ok");
            @(negedge clk);
        end
        // a hit answers in the lookup cycle
        if (code[1])
            check_value("data_ok latency", waited, 1);
        if (!code[0])
            check_value("rdata", rdata, stim[n*5+4]);
    endtask

    // refill reads the line of the pending request
    always @(negedge clk) begin
        if (resetn && rd_req)
            check_value("rd_addr", rd_addr, {tag, index, 4'h0});
        // only lines that took a store can go back dirty
        if (resetn && wr_req) begin
            assert (stored_lines.exists(wr_addr[31:4]))
            else fail_run($sformatf("write-back of line %h that was never stored to",
                                    wr_addr));
            check_value("wr_addr[11:0]", wr_addr[11:0], {index, 4'h0});
        end
    end

    initial begin
        resetn = 1'b0;
        op     = cache_ctrl_pkg::op_read;
        {valid, tag, index, offset, wstrb, wdata} = '0;
        $readmemh("tb/cache_testdata.txt", stim);
        repeat (4) @(posedge clk);
        #10;
        resetn = 1'b1;
        @(negedge clk);
        assert (!addr_ok && !data_ok && !rd_req && !wr_req)
        else fail_run($sformatf(
            "MISMATCH at %0t: addr_ok/data_ok/rd_req/wr_req is %b, expected 0000",
            $time, {addr_ok, data_ok, rd_req, wr_req}));
        k = 0;
        while (k < MAX_REQ && stim[k*5][7:0] != 8'hff) begin
            run_request(k);
            k++;
        end
        if (k == 0) begin
            fail_run("no requests found in the stimulus file");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: tb/mem_model.sv
`default_nettype none

module mem_model (
    input  wire          clk,
    input  wire          rd_req,
    input  wire  [31:0]  rd_addr,
    output logic         rd_rdy,
    output logic         ret_valid,
    output logic         ret_last,
    output logic [31:0]  ret_data,
    input  wire          wr_req,
    input  wire  [31:0]  wr_addr,
    input  wire  [127:0] wr_data,
    output logic         wr_rdy
);

    logic [127:0] lines [logic [27:0]];
    logic [31:0]  rng;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // lines never written back hold the inverted byte address
    function automatic logic [31:0] line_word(input logic [27:0] line_addr,
                                              input logic [1:0]  bank);
        if (lines.exists(line_addr))
            return lines[line_addr][bank*32 +: 32];
        return ~{line_addr, bank, 2'b00};
    endfunction

    // 0 to 3 cycles before a ready
    task automatic ready_delay();
        rng = lcg_next(rng);
        repeat (rng[17:16]) begin
            @(posedge clk);
            #10;
        end
    endtask

    initial begin
        rng = 32'd36319;
        {rd_rdy, ret_valid, ret_last, ret_data, wr_rdy} = '0;
        forever begin
            @(posedge clk);
            #10;
            if (wr_req) begin
                ready_delay();
                lines[wr_addr[31:4]] = wr_data;
                wr_rdy = 1'b1;
                @(posedge clk);
                #10;
                wr_rdy = 1'b0;
            end else if (rd_req) begin
                ready_delay();
                rd_rdy = 1'b1;
                @(posedge clk);
                #10;
                rd_rdy = 1'b0;
                // whole line, bank 0 first
                for (int b = 0; b < 4; b++) begin
                    ret_valid = 1'b1;
                    ret_last  = b == 3;
                    ret_data  = line_word(rd_addr[31:4], b[1:0]);
                    @(posedge clk);
                    #10;
                end
                {ret_valid, ret_last} = 2'b00;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/cache_top.sv
`default_nettype none

module cache_top (
    input  wire                                     clk,
    input  wire                                     resetn,
    input  wire                                     valid,
    input  wire cache_ctrl_pkg::cache_op_t          op,
    input  wire [cache_geom_pkg::INDEX_W-1:0]       index,
    input  wire [cache_geom_pkg::TAG_W-1:0]         tag,
    input  wire [cache_geom_pkg::OFFSET_W-1:0]      offset,
    input  wire [cache_geom_pkg::STRB_W-1:0]        wstrb,
    input  wire [cache_geom_pkg::WORD_W-1:0]        wdata,
    output logic                                    addr_ok,
    output logic                                    data_ok,
    output logic [cache_geom_pkg::WORD_W-1:0]       rdata,
    output logic                                    rd_req,
    output logic [cache_geom_pkg::ADDR_W-1:0]       rd_addr,
    input  wire                                     rd_rdy,
    input  wire                                     ret_valid,
    input  wire                                     ret_last,
    input  wire [cache_geom_pkg::WORD_W-1:0]        ret_data,
    output logic                                    wr_req,
    output logic [cache_geom_pkg::ADDR_W-1:0]       wr_addr,
    output logic [cache_geom_pkg::LINE_W-1:0]       wr_data,
    input  wire                                     wr_rdy
);

    logic [cache_geom_pkg::INDEX_W-1:0]                      set_index;
    logic                                                    way0_tag_we;
    logic [cache_geom_pkg::TAG_W-1:0]                        way0_tag_wdata;
    logic [cache_geom_pkg::BANKS*cache_geom_pkg::STRB_W-1:0] way0_bank_we;
    logic [cache_geom_pkg::WORD_W-1:0]                       way0_bank_wdata;
    logic                                                    way0_dirty_we;
    logic                                                    way0_dirty_wdata;
    logic                                                    way0_valid;
    logic [cache_geom_pkg::TAG_W-1:0]                        way0_tag;
    logic [cache_geom_pkg::LINE_W-1:0]                       way0_line;
    logic                                                    way0_dirty;
    logic                                                    way1_tag_we;
    logic [cache_geom_pkg::TAG_W-1:0]                        way1_tag_wdata;
    logic [cache_geom_pkg::BANKS*cache_geom_pkg::STRB_W-1:0] way1_bank_we;
    logic [cache_geom_pkg::WORD_W-1:0]                       way1_bank_wdata;
    logic                                                    way1_dirty_we;
    logic                                                    way1_dirty_wdata;
    logic                                                    way1_valid;
    logic [cache_geom_pkg::TAG_W-1:0]                        way1_tag;
    logic [cache_geom_pkg::LINE_W-1:0]                       way1_line;
    logic                                                    way1_dirty;

    logic                                                    miss_start;
    logic                                                    refill_active;
    logic [cache_geom_pkg::INDEX_W-1:0]                      req_index;
    logic [cache_geom_pkg::TAG_W-1:0]                        req_tag;
    logic [cache_geom_pkg::OFFSET_W-1:0]                     req_offset;
    logic [cache_geom_pkg::STRB_W-1:0]                       req_wstrb;
    logic [cache_geom_pkg::WORD_W-1:0]                       req_wdata;
    cache_ctrl_pkg::cache_op_t                               req_op;
    logic                                                    victim_way;
    logic [cache_geom_pkg::BANK_SEL_W-1:0]                   refill_bank;
    logic [cache_geom_pkg::STRB_W-1:0]                       refill_strb_we;
    logic [cache_geom_pkg::WORD_W-1:0]                       refill_word;
    logic                                                    writeback_done;
    logic                                                    refill_done;

    cache_ctrl ctrl (.*);

    cache_way way0 (
        .clk         (clk),
        .resetn      (resetn),
        .set_index   (set_index),
        .tag_we      (way0_tag_we),
        .tag_wdata   (way0_tag_wdata),
        .bank_we     (way0_bank_we),
        .bank_wdata  (way0_bank_wdata),
        .dirty_we    (way0_dirty_we),
        .dirty_wdata (way0_dirty_wdata),
        .valid       (way0_valid),
        .tag         (way0_tag),
        .line        (way0_line),
        .dirty       (way0_dirty)
    );

    cache_way way1 (
        .clk         (clk),
        .resetn      (resetn),
        .set_index   (set_index),
        .tag_we      (way1_tag_we),
        .tag_wdata   (way1_tag_wdata),
        .bank_we     (way1_bank_we),
        .bank_wdata  (way1_bank_wdata),
        .dirty_we    (way1_dirty_we),
        .dirty_wdata (way1_dirty_wdata),
        .valid       (way1_valid),
        .tag         (way1_tag),
        .line        (way1_line),
        .dirty       (way1_dirty)
    );

    miss_unit miss (.*);

endmodule

`default_nettype wire

// File: logic/cache_ctrl.sv
`default_nettype none

module cache_ctrl (
    input  wire                                     clk,
    input  wire                                     resetn,
    input  wire                                     valid,
    input  wire cache_ctrl_pkg::cache_op_t          op,
    input  wire [cache_geom_pkg::INDEX_W-1:0]       index,
    input  wire [cache_geom_pkg::TAG_W-1:0]         tag,
    input  wire [cache_geom_pkg::OFFSET_W-1:0]      offset,
    input  wire [cache_geom_pkg::STRB_W-1:0]        wstrb,
    input  wire [cache_geom_pkg::WORD_W-1:0]        wdata,
    output logic                                    addr_ok,
    output logic                                    data_ok,
    output logic [cache_geom_pkg::WORD_W-1:0]       rdata,
    output logic                                    rd_req,
    output logic [cache_geom_pkg::ADDR_W-1:0]       rd_addr,
    input  wire                                     rd_rdy,
    input  wire                                     ret_valid,
    input  wire                                     ret_last,
    input  wire [cache_geom_pkg::WORD_W-1:0]        ret_data,
    input  wire                                     way0_valid,
    input  wire [cache_geom_pkg::TAG_W-1:0]         way0_tag,
    input  wire [cache_geom_pkg::LINE_W-1:0]        way0_line,
    input  wire                                     way0_dirty,
    input  wire                                     way1_valid,
    input  wire [cache_geom_pkg::TAG_W-1:0]         way1_tag,
    input  wire [cache_geom_pkg::LINE_W-1:0]        way1_line,
    input  wire                                     way1_dirty,
    input  wire [cache_geom_pkg::BANK_SEL_W-1:0]    refill_bank,
    input  wire [cache_geom_pkg::STRB_W-1:0]        refill_strb_we,
    input  wire [cache_geom_pkg::WORD_W-1:0]        refill_word,
    input  wire                                     writeback_done,
    input  wire                                     refill_done,
    output logic [cache_geom_pkg::INDEX_W-1:0]      set_index,
    output logic                                    way0_tag_we,
    output logic [cache_geom_pkg::TAG_W-1:0]        way0_tag_wdata,
    output logic [cache_geom_pkg::BANKS*cache_geom_pkg::STRB_W-1:0] way0_bank_we,
    output logic [cache_geom_pkg::WORD_W-1:0]       way0_bank_wdata,
    output logic                                    way0_dirty_we,
    output logic                                    way0_dirty_wdata,
    output logic                                    way1_tag_we,
    output logic [cache_geom_pkg::TAG_W-1:0]        way1_tag_wdata,
    output logic [cache_geom_pkg::BANKS*cache_geom_pkg::STRB_W-1:0] way1_bank_we,
    output logic [cache_geom_pkg::WORD_W-1:0]       way1_bank_wdata,
    output logic                                    way1_dirty_we,
    output logic                                    way1_dirty_wdata,
    output logic                                    miss_start,
    output logic                                    refill_active,
    output logic [cache_geom_pkg::INDEX_W-1:0]      req_index,
    output logic [cache_geom_pkg::TAG_W-1:0]        req_tag,
    output logic [cache_geom_pkg::OFFSET_W-1:0]     req_offset,
    output logic [cache_geom_pkg::STRB_W-1:0]       req_wstrb,
    output logic [cache_geom_pkg::WORD_W-1:0]       req_wdata,
    output cache_ctrl_pkg::cache_op_t               req_op,
    output logic                                    victim_way
);

    cache_ctrl_pkg::main_state_t                             main_state;
    cache_ctrl_pkg::main_state_t                             main_next;
    cache_ctrl_pkg::wbuf_state_t                             wbuf_state;
    logic [cache_ctrl_pkg::LFSR_W-1:0]                       lfsr;
    logic                                                    lookup;
    logic                                                    way0_hit;
    logic                                                    way1_hit;
    logic                                                    hit;
    logic                                                    write_hit;
    logic                                                    wbuf_act;
    logic                                                    wb_way;
    logic [cache_geom_pkg::BANK_SEL_W-1:0]                   req_bank;
    logic [cache_geom_pkg::LINE_W-1:0]                       hit_line;
    logic [cache_geom_pkg::BANKS*cache_geom_pkg::STRB_W-1:0] wbuf_we;
    logic [cache_geom_pkg::BANKS*cache_geom_pkg::STRB_W-1:0] refill_we;

    // byte enables of one bank placed in the per-bank strobe vector
    function automatic logic [cache_geom_pkg::BANKS*cache_geom_pkg::STRB_W-1:0] bank_strobes(
        input logic [cache_geom_pkg::BANK_SEL_W-1:0] bank,
        input logic [cache_geom_pkg::STRB_W-1:0]     strb
    );
        logic [cache_geom_pkg::BANKS*cache_geom_pkg::STRB_W-1:0] we;
        we = '0;
        we[bank*cache_geom_pkg::STRB_W +: cache_geom_pkg::STRB_W] = strb;
        return we;
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            main_state <= cache_ctrl_pkg::main_idle;
        end else begin
            main_state <= main_next;
        end
    end

    always_comb begin
        main_next = main_state;
        case (main_state)
            cache_ctrl_pkg::main_idle:
                if (addr_ok)
                    main_next = cache_ctrl_pkg::main_lookup;
            cache_ctrl_pkg::main_lookup:
                main_next = hit ? cache_ctrl_pkg::main_idle : cache_ctrl_pkg::main_miss;
            cache_ctrl_pkg::main_miss:
                if (writeback_done)
                    main_next = cache_ctrl_pkg::main_replace;
            cache_ctrl_pkg::main_replace:
                if (rd_rdy)
                    main_next = cache_ctrl_pkg::main_refill;
            cache_ctrl_pkg::main_refill:
                if (ret_valid && ret_last)
                    main_next = cache_ctrl_pkg::main_idle;
            default:
                main_next = cache_ctrl_pkg::main_idle;
        endcase
    end

    // taps for x^23 + x^18 + 1
    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr <= cache_ctrl_pkg::LFSR_SEED;
        end else begin
            lfsr <= {lfsr[cache_ctrl_pkg::LFSR_W-2:0], lfsr[cache_ctrl_pkg::LFSR_W-1] ^ lfsr[17]};
        end
    end

    // request buffer, held until the next accept
    always_ff @(posedge clk) begin
        if (addr_ok) begin
            req_op     <= op;
            req_index  <= index;
            req_tag    <= tag;
            req_offset <= offset;
            req_wstrb  <= wstrb;
            req_wdata  <= wdata;
            victim_way <= lfsr[0];
        end
    end

    assign lookup    = main_state == cache_ctrl_pkg::main_lookup;
    assign way0_hit  = way0_valid && way0_tag == req_tag;
    assign way1_hit  = way1_valid && way1_tag == req_tag;
    assign hit       = lookup && (way0_hit || way1_hit);
    assign write_hit = hit && req_op == cache_ctrl_pkg::op_write;
    assign req_bank  = req_offset[cache_geom_pkg::OFFSET_W-1 -: cache_geom_pkg::BANK_SEL_W];
    assign hit_line  = way1_hit ? way1_line : way0_line;

    assign miss_start    = lookup && !(way0_hit || way1_hit);
    assign refill_active = main_state == cache_ctrl_pkg::main_refill;

    assign addr_ok = valid && main_state == cache_ctrl_pkg::main_idle
                     && wbuf_state == cache_ctrl_pkg::wbuf_idle;
    assign data_ok = hit || (refill_active && ret_valid && refill_bank == req_bank);
    assign rdata   = refill_active ? ret_data
                                   : hit_line[req_bank*cache_geom_pkg::WORD_W +: cache_geom_pkg::WORD_W];

    assign rd_req  = main_state == cache_ctrl_pkg::main_replace;
    assign rd_addr = {req_tag, req_index, {cache_geom_pkg::OFFSET_W{1'b0}}};

    // write buffer records the hit way, store data stays in the request buffer
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wbuf_state <= cache_ctrl_pkg::wbuf_idle;
        end else if (write_hit) begin
            wbuf_state <= cache_ctrl_pkg::wbuf_write;
        end else begin
            wbuf_state <= cache_ctrl_pkg::wbuf_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (write_hit)
            wb_way <= way1_hit;
    end

    assign wbuf_act  = wbuf_state == cache_ctrl_pkg::wbuf_write;
    assign set_index = addr_ok ? index : req_index;
    assign wbuf_we   = bank_strobes(req_bank, req_wstrb);
    assign refill_we = bank_strobes(refill_bank, refill_strb_we);

    assign way0_bank_we    = (wbuf_act && !wb_way) ? wbuf_we : (victim_way ? '0 : refill_we);
    assign way1_bank_we    = (wbuf_act && wb_way) ? wbuf_we : (victim_way ? refill_we : '0);
    assign way0_bank_wdata = wbuf_act ? req_wdata : refill_word;
    assign way1_bank_wdata = wbuf_act ? req_wdata : refill_word;

    // tag and valid go in with the last refill word
    assign way0_tag_we    = refill_done && !victim_way;
    assign way1_tag_we    = refill_done && victim_way;
    assign way0_tag_wdata = req_tag;
    assign way1_tag_wdata = req_tag;

    // skip the dirty write when the hit line is dirty already
    assign way0_dirty_we    = (write_hit && way0_hit && !way0_dirty) || way0_tag_we;
    assign way1_dirty_we    = (write_hit && way1_hit && !way1_dirty) || way1_tag_we;
    assign way0_dirty_wdata = req_op == cache_ctrl_pkg::op_write;
    assign way1_dirty_wdata = req_op == cache_ctrl_pkg::op_write;

    assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> main_state inside {cache_ctrl_pkg::main_lookup, cache_ctrl_pkg::main_refill});

    // read request held with its address until taken
    assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr));

endmodule

`default_nettype wire

// File: logic/miss_unit.sv
`default_nettype none

module miss_unit (
    input  wire                                     clk,
    input  wire                                     resetn,
    input  wire                                     miss_start,
    input  wire                                     refill_active,
    input  wire                                     victim_way,
    input  wire [cache_geom_pkg::TAG_W-1:0]         way0_tag,
    input  wire [cache_geom_pkg::LINE_W-1:0]        way0_line,
    input  wire                                     way0_valid,
    input  wire                                     way0_dirty,
    input  wire [cache_geom_pkg::TAG_W-1:0]         way1_tag,
    input  wire [cache_geom_pkg::LINE_W-1:0]        way1_line,
    input  wire                                     way1_valid,
    input  wire                                     way1_dirty,
    input  wire [cache_geom_pkg::INDEX_W-1:0]       req_index,
    input  wire [cache_geom_pkg::TAG_W-1:0]         req_tag,
    input  wire [cache_geom_pkg::OFFSET_W-1:0]      req_offset,
    input  wire [cache_geom_pkg::STRB_W-1:0]        req_wstrb,
    input  wire [cache_geom_pkg::WORD_W-1:0]        req_wdata,
    input  wire cache_ctrl_pkg::cache_op_t          req_op,
    input  wire                                     ret_valid,
    input  wire                                     ret_last,
    input  wire [cache_geom_pkg::WORD_W-1:0]        ret_data,
    input  wire                                     wr_rdy,
    output logic                                    wr_req,
    output logic [cache_geom_pkg::ADDR_W-1:0]       wr_addr,
    output logic [cache_geom_pkg::LINE_W-1:0]       wr_data,
    output logic                                    writeback_done,
    output logic [cache_geom_pkg::BANK_SEL_W-1:0]   refill_bank,
    output logic [cache_geom_pkg::STRB_W-1:0]       refill_strb_we,
    output logic [cache_geom_pkg::WORD_W-1:0]       refill_word,
    output logic                                    refill_done
);

    logic [cache_geom_pkg::TAG_W-1:0] victim_tag;
    logic                             ret_beat;

    // victim line captured during lookup
    always_ff @(posedge clk) begin
        if (miss_start) begin
            victim_tag <= victim_way ? way1_tag : way0_tag;
            wr_data    <= victim_way ? way1_line : way0_line;
        end
    end

    // dirty victim raises wr_req in the first miss cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_req <= 1'b0;
        end else if (miss_start) begin
            wr_req <= victim_way ? (way1_valid && way1_dirty) : (way0_valid && way0_dirty);
        end else if (wr_rdy) begin
            wr_req <= 1'b0;
        end
    end

    assign wr_addr        = {victim_tag, req_index, {cache_geom_pkg::OFFSET_W{1'b0}}};
    assign writeback_done = !wr_req || wr_rdy;

    // words come back in bank order
    assign ret_beat       = refill_active && ret_valid;
    assign refill_done    = ret_beat && ret_last;
    assign refill_strb_we = {cache_geom_pkg::STRB_W{ret_beat}};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            refill_bank <= '0;
        end else if (refill_done) begin
            refill_bank <= '0;
        end else if (ret_beat) begin
            refill_bank <= refill_bank + 1'b1;
        end
    end

    // store bytes override the returned word
    always_comb begin
        refill_word = ret_data;
        if (req_op == cache_ctrl_pkg::op_write
            && refill_bank == req_offset[cache_geom_pkg::OFFSET_W-1 -: cache_geom_pkg::BANK_SEL_W]) begin
            for (int b = 0; b < cache_geom_pkg::STRB_W; b++) begin
                if (req_wstrb[b])
                    refill_word[b*8 +: 8] = req_wdata[b*8 +: 8];
            end
        end
    end

    assert property (@(posedge clk) disable iff (!resetn)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr));

endmodule

`default_nettype wire

// File: logic/cache_way.sv
`default_nettype none

module cache_way (
    input  wire                                     clk,
    input  wire                                     resetn,
    input  wire [cache_geom_pkg::INDEX_W-1:0]       set_index,
    input  wire                                     tag_we,
    input  wire [cache_geom_pkg::TAG_W-1:0]         tag_wdata,
    input  wire [cache_geom_pkg::BANKS*cache_geom_pkg::STRB_W-1:0] bank_we,
    input  wire [cache_geom_pkg::WORD_W-1:0]        bank_wdata,
    input  wire                                     dirty_we,
    input  wire                                     dirty_wdata,
    output logic                                    valid,
    output logic [cache_geom_pkg::TAG_W-1:0]        tag,
    output logic [cache_geom_pkg::LINE_W-1:0]       line,
    output logic                                    dirty
);

    logic [cache_geom_pkg::TAG_W-1:0]  tag_mem  [cache_geom_pkg::SETS];
    logic [cache_geom_pkg::WORD_W-1:0] bank_mem [cache_geom_pkg::BANKS][cache_geom_pkg::SETS];
    logic [cache_geom_pkg::SETS-1:0]   valid_bits;
    logic [cache_geom_pkg::SETS-1:0]   dirty_bits;

    // all reads return one cycle after the index
    always_ff @(posedge clk) begin
        if (tag_we)
            tag_mem[set_index] <= tag_wdata;
        tag <= tag_mem[set_index];
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < cache_geom_pkg::BANKS; b++) begin
            for (int s = 0; s < cache_geom_pkg::STRB_W; s++) begin
                if (bank_we[b*cache_geom_pkg::STRB_W + s])
                    bank_mem[b][set_index][s*8 +: 8] <= bank_wdata[s*8 +: 8];
            end
            line[b*cache_geom_pkg::WORD_W +: cache_geom_pkg::WORD_W] <= bank_mem[b][set_index];
        end
    end

    // valid only ever set, by a tag write
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (tag_we)
                valid_bits[set_index] <= 1'b1;
            if (dirty_we)
                dirty_bits[set_index] <= dirty_wdata;
        end
    end

    always_ff @(posedge clk) begin
        valid <= valid_bits[set_index];
        dirty <= dirty_bits[set_index];
    end

    assert property (@(posedge clk) disable iff (!resetn)
        tag_we |=> valid_bits[$past(set_index)]);

endmodule

`default_nettype wire

// File: logic/cache_ctrl_pkg.sv
`default_nettype none

package cache_ctrl_pkg;

    // one-hot main states
    typedef enum logic [4:0] {
        main_idle    = 5'b00001,
        main_lookup  = 5'b00010,
        main_miss    = 5'b00100,
        main_replace = 5'b01000,
        main_refill  = 5'b10000
    } main_state_t;

    typedef enum logic {
        wbuf_idle  = 1'b0,
        wbuf_write = 1'b1
    } wbuf_state_t;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } cache_op_t;

    localparam int LFSR_W = 23;
    localparam logic [LFSR_W-1:0] LFSR_SEED = '1;

endpackage

`default_nettype wire

// File: logic/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    // address split is tag | index | offset
    localparam int TAG_W      = 20;
    localparam int INDEX_W    = 8;
    localparam int OFFSET_W   = 4;
    localparam int ADDR_W     = TAG_W + INDEX_W + OFFSET_W;

    localparam int WORD_W     = 32;
    localparam int STRB_W     = WORD_W / 8;

    // a line is four word banks
    localparam int BANKS      = 4;
    localparam int BANK_SEL_W = 2;
    localparam int LINE_W     = WORD_W * BANKS;
    localparam int SETS       = 1 << INDEX_W;

endpackage

`default_nettype wire
